//--- source/tab_pkg.sv
`default_nettype none

package tab_pkg;

        //////////////////////////////
        // table geometry
        //////////////////////////////
        localparam int tab_awid  = 8;              // 256 entries
        localparam int tab_dwid  = 8;              // entry width
        localparam int max_users = 4;              // bounds the user id width

        //////////////////////////////
        // types
        //////////////////////////////
        typedef logic [tab_awid-1:0] tab_addr_t;
        typedef logic [tab_dwid-1:0] tab_data_t;

        // index of a requesting user
        typedef logic [$clog2(max_users)-1:0] user_id_t;

endpackage

`default_nettype wire

//--- source/arb_pkg.sv
`default_nettype none

package arb_pkg;

        // idle waits for a legal grant, grant pops, hold issues the request
        typedef enum logic [1:0] {
                arb_idle  = 2'd0,
                arb_grant = 2'd1,
                arb_hold  = 2'd2
        } arb_state_e;

        typedef logic [3:0] gap_cnt_t;             // saturates at 15

endpackage

`default_nettype wire

//--- source/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
        parameter int width     = 8,
        parameter int fifo_awid = 5,
        parameter int afull_th  = 8
) (
        input  wire logic             clk,
        input  wire logic             rst,
        input  wire logic             wen,
        input  wire logic [width-1:0] wdata,
        output logic                  nafull,
        input  wire logic             ren,
        output logic      [width-1:0] rdata,
        output logic                  nempty
);

        localparam int depth = 1 << fifo_awid;

        logic [width-1:0]     mem [0:depth-1];
        logic [fifo_awid-1:0] wptr;
        logic [fifo_awid-1:0] rptr;
        logic [fifo_awid-1:0] rptr_nxt;                // head address for next cycle
        logic [fifo_awid:0]   used;

        assign rptr_nxt = ren ? rptr + 1'b1 : rptr;
        assign nempty   = (used != '0);
        assign nafull   = (used < (fifo_awid+1)'(depth - afull_th)); // more than afull_th free

        //////////////////////////////
        // pointers and fill level
        //////////////////////////////
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        wptr <= '0;
                        rptr <= '0;
                        used <= '0;
                end else begin
                        if (wen)
                                wptr <= wptr + 1'b1;
                        rptr <= rptr_nxt;
                        case ({wen, ren})
                                2'b10:   used <= used + 1'b1;
                                2'b01:   used <= used - 1'b1;
                                default: used <= used;
                        endcase
                end
        end

        // head register, bypassed when the write lands on the next head
        always_ff @(posedge clk) begin
                if (wen)
                        mem[wptr] <= wdata;
                if (wen && (wptr == rptr_nxt))
                        rdata <= wdata;                 // write into empty slot at head
                else
                        rdata <= mem[rptr_nxt];
        end

        a_no_overflow : assert property (@(posedge clk) disable iff (rst)
                wen |-> (used != (fifo_awid+1)'(depth)));
        a_no_underflow : assert property (@(posedge clk) disable iff (rst)
                ren |-> nempty);

endmodule

`default_nettype wire

//--- source/table_ram.sv
`timescale 1ns/1ns
`default_nettype none

module table_ram
        import tab_pkg::*;
(
        input  wire logic      clk,
        input  wire logic      wen,
        input  wire tab_addr_t waddr,
        input  wire tab_data_t wdata,
        input  wire logic      ren,
        input  wire tab_addr_t raddr,
        output tab_data_t      rdata
);

        localparam int depth = 1 << tab_awid;

        tab_data_t mem [0:depth-1];

        always_ff @(posedge clk) begin
                if (wen)
                        mem[waddr] <= wdata;
        end

        // read returns old contents on a same-address write
        always_ff @(posedge clk) begin
                if (ren)
                        rdata <= mem[raddr];
        end

endmodule

`default_nettype wire

//--- source/table_writer.sv
`timescale 1ns/1ns
`default_nettype none

module table_writer
        import tab_pkg::*;
(
        input  wire logic      clk,
        input  wire logic      rst,
        input  wire logic      wreq_wen,
        input  wire tab_addr_t wreq_addr,
        input  wire logic      wdat_wen,
        input  wire tab_data_t wdat_data,
        output logic           ram_wen,
        output tab_addr_t      ram_waddr,
        output tab_data_t      ram_wdata
);

        tab_addr_t cur_addr;                            // address of next data strobe
        tab_addr_t wr_addr;

        assign wr_addr = wreq_wen ? wreq_addr : cur_addr; // new address wins

        //////////////////////////////
        // address counter
        //////////////////////////////
        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        cur_addr <= '0;
                else if (wdat_wen)
                        cur_addr <= wr_addr + 1'b1;
                else if (wreq_wen)
                        cur_addr <= wreq_addr;
        end

        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        ram_wen <= 1'b0;
                else
                        ram_wen <= wdat_wen;
        end

        always_ff @(posedge clk) begin
                if (wdat_wen) begin
                        ram_waddr <= wr_addr;
                        ram_wdata <= wdat_data;
                end
        end

endmodule

`default_nettype wire

//--- source/burst_reader.sv
`timescale 1ns/1ns
`default_nettype none

module burst_reader
        import tab_pkg::*;
#(
        parameter int burst_len = 2
) (
        input  wire logic      clk,
        input  wire logic      rst,
        input  wire logic      ctr_rreq_wen,
        input  wire tab_addr_t ctr_rreq_addr,
        output logic           ram_ren,
        output tab_addr_t      ram_raddr,
        input  wire tab_data_t ram_rdata,
        output logic           ctr_rdat_wen,
        output tab_data_t      ctr_rdat_data
);

        localparam int cnt_w = $clog2(burst_len + 1);

        logic [cnt_w-1:0] rd_left;                      // reads remaining after this one
        logic [1:0]       vld_q;                        // ram stage, output stage

        //////////////////////////////
        // read sequencing
        //////////////////////////////
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        ram_ren <= 1'b0;
                        rd_left <= '0;
                end else if (ctr_rreq_wen) begin
                        ram_ren <= 1'b1;
                        rd_left <= cnt_w'(burst_len - 1);
                end else if (ram_ren) begin
                        if (rd_left == '0)
                                ram_ren <= 1'b0;        // burst done
                        else
                                rd_left <= rd_left - 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (ctr_rreq_wen)
                        ram_raddr <= ctr_rreq_addr;
                else if (ram_ren)
                        ram_raddr <= ram_raddr + 1'b1;  // wraps at 256
        end

        //////////////////////////////
        // return path
        //////////////////////////////
        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        vld_q <= '0;
                else
                        vld_q <= {vld_q[0], ram_ren};
        end

        always_ff @(posedge clk) begin
                if (vld_q[0])
                        ctr_rdat_data <= ram_rdata;
        end

        assign ctr_rdat_wen = vld_q[1];

        a_no_overlap : assert property (@(posedge clk) disable iff (rst)
                ctr_rreq_wen |-> !ram_ren);

endmodule

`default_nettype wire

//--- source/rreq_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rreq_arbiter
        import tab_pkg::*;
        import arb_pkg::*;
#(
        parameter int user_num  = 2,
        parameter int burst_len = 2
) (
        input  wire logic                     clk,
        input  wire logic                     rst,
        output logic     [user_num-1:0]       in_ren,
        input  wire tab_addr_t [user_num-1:0] in_rdata,
        input  wire logic [user_num-1:0]      in_nempty,
        output logic                          id_wen,
        output user_id_t                      id_wdata,
        input  wire logic                     id_nafull,
        input  wire logic [user_num-1:0]      rdat_nafull,
        output logic                          ctr_rreq_wen,
        output tab_addr_t                     ctr_rreq_addr
);

        arb_state_e state;
        gap_cnt_t   gap_cnt;                            // cycles since last decision
        user_id_t   gnt_id;                             // last granted user, rr pointer
        user_id_t   pick_id;
        logic       pick_vld;
        logic       grant_ok;

        //////////////////////////////
        // round robin pick
        //////////////////////////////
        always_comb begin
                int idx;
                pick_vld = 1'b0;
                pick_id  = gnt_id;
                for (int i = 1; i <= user_num; i++) begin
                        idx = (int'(gnt_id) + i) % user_num; // start after last winner
                        if (!pick_vld && in_nempty[idx]) begin
                                pick_vld = 1'b1;
                                pick_id  = user_id_t'(idx);
                        end
                end
        end

        assign grant_ok = (state == arb_idle) && (gap_cnt >= gap_cnt_t'(burst_len)) &&
                          pick_vld && id_nafull && (&rdat_nafull);

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        state   <= arb_idle;
                        gap_cnt <= '1;                  // first grant needs no wait
                        gnt_id  <= user_id_t'(user_num - 1);
                end else begin
                        case (state)
                                arb_idle:  if (grant_ok) state <= arb_grant;
                                arb_grant: state <= arb_hold;
                                arb_hold:  state <= arb_idle;
                                default:   state <= arb_idle;
                        endcase
                        if (grant_ok) begin
                                gap_cnt <= '0;
                                gnt_id  <= pick_id;
                        end else if (gap_cnt != '1) begin
                                gap_cnt <= gap_cnt + 1'b1;
                        end
                end
        end

        // pop and id push happen in the grant cycle
        assign in_ren   = (state == arb_grant) ? (user_num'(1) << gnt_id) : '0;
        assign id_wen   = (state == arb_grant);
        assign id_wdata = gnt_id;

        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        ctr_rreq_wen <= 1'b0;
                else
                        ctr_rreq_wen <= (state == arb_hold);
        end

        always_ff @(posedge clk) begin
                if (state == arb_grant)
                        ctr_rreq_addr <= in_rdata[gnt_id];  // head word, popped this cycle
        end

        // a pop hits exactly one queue that holds a request
        a_ren_onehot : assert property (@(posedge clk) disable iff (rst)
                (state == arb_grant) |-> $onehot(in_ren & in_nempty));

endmodule

`default_nettype wire

//--- source/rdat_router.sv
`timescale 1ns/1ns
`default_nettype none

module rdat_router
        import tab_pkg::*;
#(
        parameter int user_num  = 2,
        parameter int burst_len = 2
) (
        input  wire logic                clk,
        input  wire logic                rst,
        input  wire logic                ctr_rdat_wen,
        input  wire tab_data_t           ctr_rdat_data,
        output logic                     id_ren,
        input  wire user_id_t            id_rdata,
        input  wire logic                id_nempty,
        output logic [user_num-1:0]      rdat_wen,
        output tab_data_t                rdat_data
);

        localparam int cnt_w = $clog2(burst_len + 1);

        logic [cnt_w-1:0] wcnt;                         // words seen in current burst
        logic             last_word;

        assign last_word = (wcnt == cnt_w'(burst_len - 1));
        assign id_ren    = ctr_rdat_wen && last_word;   // retire owner after its burst

        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        wcnt <= '0;
                else if (ctr_rdat_wen)
                        wcnt <= last_word ? '0 : wcnt + 1'b1;
        end

        //////////////////////////////
        // steer to owner
        //////////////////////////////
        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        rdat_wen <= '0;
                else
                        rdat_wen <= ctr_rdat_wen ? (user_num'(1) << id_rdata) : '0;
        end

        always_ff @(posedge clk) begin
                rdat_data <= ctr_rdat_data;             // shared by all users
        end

        // every returned word must have an owner queued by the arbiter
        a_owner_known : assert property (@(posedge clk) disable iff (rst)
                ctr_rdat_wen |-> id_nempty);

endmodule

`default_nettype wire

//--- source/toe_tab.sv
`timescale 1ns/1ns
`default_nettype none

module toe_tab
        import tab_pkg::*;
#(
        parameter int user_num  = 2,
        parameter int burst_len = 2,
        parameter int fifo_awid = 5,
        parameter int afull_th  = 8
) (
        input  wire logic                     clk,
        input  wire logic                     rst,
        input  wire logic [user_num-1:0]      rreq_wen,
        input  wire tab_addr_t [user_num-1:0] rreq_addr,
        output logic      [user_num-1:0]      rreq_nafull,
        output logic      [user_num-1:0]      rdat_wen,
        output tab_data_t                     rdat_data,
        input  wire logic [user_num-1:0]      rdat_nafull,
        input  wire logic                     wreq_wen,
        input  wire tab_addr_t                wreq_addr,
        input  wire logic                     wdat_wen,
        input  wire tab_data_t                wdat_data
);

        logic      [user_num-1:0] usr_ren;
        tab_addr_t [user_num-1:0] usr_rdata;
        logic      [user_num-1:0] usr_nempty;
        logic                     id_wen, id_nafull, id_ren, id_nempty;
        user_id_t                 id_wdata, id_rdata;
        logic                     ctr_rreq_wen, ctr_rdat_wen;
        tab_addr_t                ctr_rreq_addr;
        tab_data_t                ctr_rdat_data;
        logic                     ram_ren, ram_wen;
        tab_addr_t                ram_raddr, ram_waddr;
        tab_data_t                ram_rdata, ram_wdata;

        //////////////////////////////
        // per user request queues
        //////////////////////////////
        for (genvar i = 0; i < user_num; i++) begin : g_usr
                sync_fifo #(.width(tab_awid), .fifo_awid(fifo_awid), .afull_th(afull_th))
                u_rreq_fifo (
                        .clk(clk), .rst(rst),
                        .wen(rreq_wen[i]), .wdata(rreq_addr[i]), .nafull(rreq_nafull[i]),
                        .ren(usr_ren[i]), .rdata(usr_rdata[i]), .nempty(usr_nempty[i])
                );
        end

        rreq_arbiter #(.user_num(user_num), .burst_len(burst_len)) u_arb (
                .clk(clk), .rst(rst),
                .in_ren(usr_ren), .in_rdata(usr_rdata), .in_nempty(usr_nempty),
                .id_wen(id_wen), .id_wdata(id_wdata), .id_nafull(id_nafull),
                .rdat_nafull(rdat_nafull),
                .ctr_rreq_wen(ctr_rreq_wen), .ctr_rreq_addr(ctr_rreq_addr)
        );

        // owner of each granted burst, in grant order
        sync_fifo #(.width($bits(user_id_t)), .fifo_awid(fifo_awid), .afull_th(afull_th))
        u_id_fifo (
                .clk(clk), .rst(rst),
                .wen(id_wen), .wdata(id_wdata), .nafull(id_nafull),
                .ren(id_ren), .rdata(id_rdata), .nempty(id_nempty)
        );

        //////////////////////////////
        // table and its ports
        //////////////////////////////
        burst_reader #(.burst_len(burst_len)) u_reader (
                .clk(clk), .rst(rst),
                .ctr_rreq_wen(ctr_rreq_wen), .ctr_rreq_addr(ctr_rreq_addr),
                .ram_ren(ram_ren), .ram_raddr(ram_raddr), .ram_rdata(ram_rdata),
                .ctr_rdat_wen(ctr_rdat_wen), .ctr_rdat_data(ctr_rdat_data)
        );

        table_ram u_ram (
                .clk(clk),
                .wen(ram_wen), .waddr(ram_waddr), .wdata(ram_wdata),
                .ren(ram_ren), .raddr(ram_raddr), .rdata(ram_rdata)
        );

        table_writer u_writer (
                .clk(clk), .rst(rst),
                .wreq_wen(wreq_wen), .wreq_addr(wreq_addr),
                .wdat_wen(wdat_wen), .wdat_data(wdat_data),
                .ram_wen(ram_wen), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata)
        );

        rdat_router #(.user_num(user_num), .burst_len(burst_len)) u_router (
                .clk(clk), .rst(rst),
                .ctr_rdat_wen(ctr_rdat_wen), .ctr_rdat_data(ctr_rdat_data),
                .id_ren(id_ren), .id_rdata(id_rdata), .id_nempty(id_nempty),
                .rdat_wen(rdat_wen), .rdat_data(rdat_data)
        );

endmodule

`default_nettype wire

//--- testbench/tb_toe_tab.sv
`timescale 1ns/1ns
`default_nettype none

module tb_toe_tab
        import tab_pkg::*;
();

        localparam int user_num  = 2;
        localparam int burst_len = 2;

        typedef tab_data_t [burst_len-1:0] burst_t;

        logic                     clk;
        logic                     rst;
        logic      [user_num-1:0] rreq_wen;
        tab_addr_t [user_num-1:0] rreq_addr;
        logic      [user_num-1:0] rreq_nafull;
        logic      [user_num-1:0] rdat_wen;
        tab_data_t                rdat_data;
        logic      [user_num-1:0] rdat_nafull;
        logic                     wreq_wen;
        tab_addr_t                wreq_addr;
        logic                     wdat_wen;
        tab_data_t                wdat_data;

        tab_data_t   shadow [0:255];                    // expected table contents
        tab_data_t   exp_q0 [$];
        tab_data_t   exp_q1 [$];
        int unsigned lcg_state = 97326;
        int          err_cnt   = 0;
        int          check_cnt = 0;
        int          test_cnt  = 0;
        int          word_cnt  = 0;                     // words seen on rdat_wen

        toe_tab #(.user_num(user_num), .burst_len(burst_len), .fifo_awid(5), .afull_th(8))
        dut_i (
                .clk(clk), .rst(rst),
                .rreq_wen(rreq_wen), .rreq_addr(rreq_addr), .rreq_nafull(rreq_nafull),
                .rdat_wen(rdat_wen), .rdat_data(rdat_data), .rdat_nafull(rdat_nafull),
                .wreq_wen(wreq_wen), .wreq_addr(wreq_addr),
                .wdat_wen(wdat_wen), .wdat_data(wdat_data)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        //////////////////////////////
        // helpers
        //////////////////////////////
        function automatic tab_data_t lcg_byte();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return 8'(lcg_state >> 16);
        endfunction

        // words a burst from addr must return, wrapping at 256
        function automatic burst_t ref_burst(input tab_addr_t addr);
                burst_t    words;
                tab_addr_t a;
                a = addr;
                for (int k = 0; k < burst_len; k++) begin
                        words[k] = shadow[a];
                        a = a + 1'b1;
                end
                return words;
        endfunction

        function automatic int pending_words();
                return exp_q0.size() + exp_q1.size();
        endfunction

        task automatic check_val(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
                check_cnt++;
                if (got !== exp) begin
                        $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
                        err_cnt++;
                end
        endtask

        task automatic queue_expected(input int u, input tab_addr_t addr);
                burst_t words;
                words = ref_burst(addr);
                for (int k = 0; k < burst_len; k++) begin
                        if (u == 0)
                                exp_q0.push_back(words[k]);
                        else
                                exp_q1.push_back(words[k]);
                end
        endtask

        task automatic take_expected(input int u, output bit found, output tab_data_t word);
                found = 1'b0;
                word  = '0;
                if (u == 0 && exp_q0.size() != 0) begin
                        found = 1'b1;
                        word  = exp_q0.pop_front();
                end else if (u == 1 && exp_q1.size() != 0) begin
                        found = 1'b1;
                        word  = exp_q1.pop_front();
                end
        endtask

        // one address strobe, then count data strobes back to back
        task automatic write_table(input tab_addr_t start, input int count);
                tab_addr_t a;
                tab_data_t d;
                a = start;
                @(posedge clk);
                wreq_wen  <= 1'b1;
                wreq_addr <= start;
                @(posedge clk);
                wreq_wen <= 1'b0;
                for (int i = 0; i < count; i++) begin
                        d = lcg_byte();
                        wdat_wen  <= 1'b1;
                        wdat_data <= d;
                        shadow[a] = d;
                        a = a + 1'b1;
                        @(posedge clk);
                end
                wdat_wen <= 1'b0;
                repeat (2) @(posedge clk);              // last entry reaches the RAM
        endtask

        task automatic drive_reqs(input logic [user_num-1:0] en, input tab_addr_t a0,
                                  input tab_addr_t a1);
                int cycles;
                cycles = 0;
                @(posedge clk);
                while (((rreq_nafull & en) != en) && cycles < 200) begin
                        @(posedge clk);
                        cycles++;
                end
                if ((rreq_nafull & en) != en) begin
                        $display("request FIFO stayed almost full, request dropped");
                        err_cnt++;
                end else begin
                        rreq_wen  <= en;
                        rreq_addr <= {a1, a0};
                        if (en[0])
                                queue_expected(0, a0);
                        if (en[1])
                                queue_expected(1, a1);
                end
                @(posedge clk);
                rreq_wen <= '0;
        endtask

        task automatic wait_drain(input string what);
                int cycles;
                cycles = 0;
                while (pending_words() != 0 && cycles < 3000) begin
                        @(posedge clk);
                        cycles++;
                end
                if (pending_words() != 0) begin
                        $display("timeout in %s, %0d words never returned", what,
                                 pending_words());
                        err_cnt++;
                end
                repeat (4) @(posedge clk);
        endtask

        // waits until no word has come back for quiet_len cycles
        task automatic wait_quiet(input int quiet_len);
                int quiet;
                int cycles;
                int last;
                quiet  = 0;
                cycles = 0;
                last   = word_cnt;
                while (quiet < quiet_len && cycles < 500) begin
                        @(posedge clk);
                        cycles++;
                        if (word_cnt == last)
                                quiet++;
                        else
                                quiet = 0;
                        last = word_cnt;
                end
                if (quiet < quiet_len) begin
                        $display("return path never went idle");
                        err_cnt++;
                end
        endtask

        task automatic report_test(input string name, input int errs_before);
                test_cnt++;
                $display("test %s: %0d errors", name, err_cnt - errs_before);
        endtask

        //////////////////////////////
        // return word checker
        //////////////////////////////
        always @(negedge clk) begin
                bit        found;
                tab_data_t exp_word;
                if (!rst) begin
                        for (int u = 0; u < user_num; u++) begin
                                if (rdat_wen[u]) begin
                                        word_cnt++;
                                        take_expected(u, found, exp_word);
                                        if (!found) begin
                                                $display("user %0d got a word it never asked for",
                                                         u);
                                                err_cnt++;
                                        end else begin
                                                check_val($sformatf("rdat_data user %0d", u),
                                                          32'(rdat_data), 32'(exp_word));
                                        end
                                end
                        end
                end
        end

        //////////////////////////////
        // test sequence
        //////////////////////////////
        initial begin
                int errs;
                int snap;
                rst         = 1'b1;
                rreq_wen    = '0;
                rreq_addr   = '0;
                rdat_nafull = '1;
                wreq_wen    = 1'b0;
                wreq_addr   = '0;
                wdat_wen    = 1'b0;
                wdat_data   = '0;
                repeat (3) @(posedge clk);
                rst <= 1'b0;
                @(posedge clk);

                errs = err_cnt;
                check_val("rdat_wen", 32'(rdat_wen), 32'd0);
                check_val("rreq_nafull", 32'(rreq_nafull), 32'(2'b11));
                report_test("reset_state", errs);

                errs = err_cnt;
                write_table(8'd0, 256);
                for (int i = 0; i < 16; i++)
                        drive_reqs(2'b01, lcg_byte(), 8'd0);
                wait_drain("write_read");
                report_test("write_read", errs);

                errs = err_cnt;
                drive_reqs(2'b01, 8'd255, 8'd0);       // 255 then 0
                drive_reqs(2'b10, 8'd0, 8'd255);
                wait_drain("burst_wrap");
                report_test("burst_wrap", errs);

                errs = err_cnt;
                snap = word_cnt;
                for (int i = 0; i < 16; i++)
                        drive_reqs(2'b11, lcg_byte(), lcg_byte());
                wait_drain("concurrent");
                check_val("word count", word_cnt - snap, 16 * 2 * burst_len);
                report_test("concurrent", errs);

                errs = err_cnt;
                for (int i = 0; i < 4; i++)
                        drive_reqs(2'b11, lcg_byte(), lcg_byte());
                @(posedge clk);
                rdat_nafull <= 2'b01;                   // user 1 return path full
                wait_quiet(10);
                if (pending_words() == 0) begin
                        $display("back-pressure came too late, no request was held");
                        err_cnt++;
                end
                snap = word_cnt;
                repeat (40) @(posedge clk);
                check_val("words while held", word_cnt - snap, 0);
                rdat_nafull <= 2'b11;
                wait_drain("back_pressure");
                report_test("back_pressure", errs);

                errs = err_cnt;
                write_table(8'd250, 12);                // also wraps the write address
                for (int i = 0; i < 13; i++)
                        drive_reqs(2'b10, 8'd0, 8'(249 + i));
                for (int i = 0; i < 6; i++)
                        drive_reqs(2'b11, lcg_byte(), lcg_byte());
                wait_drain("rewrite");
                report_test("rewrite", errs);

                $display("tests %0d, checks %0d, words %0d, errors %0d",
                         test_cnt, check_cnt, word_cnt, err_cnt);
                if (err_cnt == 0)
                        $display("TEST PASS");
                else
                        $display("TEST FAIL");
                $finish;
        end

endmodule

`default_nettype wire

//--- verilog.f
source/tab_pkg.sv
source/arb_pkg.sv
source/sync_fifo.sv
source/table_ram.sv
source/table_writer.sv
source/burst_reader.sv
source/rreq_arbiter.sv
source/rdat_router.sv
source/toe_tab.sv
testbench/tb_toe_tab.sv

//--- Makefile
SOURCES := $(shell cat verilog.f)

.PHONY: all run clean

all: obj_dir/Vtb_toe_tab

obj_dir/Vtb_toe_tab: verilog.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_toe_tab -f verilog.f

# the exit status follows the pass line in the output
run: obj_dir/Vtb_toe_tab
	obj_dir/Vtb_toe_tab | awk '{ print } /^TEST PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
